//--- sim.f
+incdir+include
rtl/decode_pkg.sv
rtl/decode_ctrl_if.sv
rtl/register_file.sv
rtl/instruction_decoder.sv
rtl/id_ex_register.sv
rtl/decode_top.sv
sim/tb_decode_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sim.f \
   --top-module tb_decode_top \
   -o tb_decode_top

./obj_dir/tb_decode_top | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"

//--- sim/tb_decode_top.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module tb_decode_top;

   logic                     clk;
   logic                     rst;
   logic [`DATA_W-1:0]       instruction;
   logic [`DATA_W-1:0]       pc;
   logic                     rf_we;
   logic [`REG_ADDR_W-1:0]   rf_addr;
   logic [`DATA_W-1:0]       rf_data;
   logic [`DATA_W-1:0]       ex_pc;
   logic [`DATA_W-1:0]       ex_a;
   logic [`DATA_W-1:0]       ex_b;
   logic [`IMM_W-1:0]        ex_imm;
   logic [`SHAMT_W-1:0]      ex_shamt;
   decode_pkg::ex_ctrl_t     ex_ctrl;
   decode_pkg::wb_ctrl_t     wb_ctrl;
   logic                     nop;
   logic                     branch;
   logic                     jump_rs;
   logic [`DATA_W-1:0]       jump_rs_addr;
   logic                     jump_imm;
   logic [`JUMP_IMM_W-1:0]   jump_imm_addr;
   logic                     rtype;

   integer                   seed;
   int                       errors;
   int                       checks;
   int                       tests;
   logic [`DATA_W-1:0]       last_pc;

   decode_top decode_top_inst (
      .i_clk           (clk),
      .i_rst           (rst),
      .i_instruction   (instruction),
      .i_pc            (pc),
      .i_rf_we         (rf_we),
      .i_rf_addr       (rf_addr),
      .i_rf_data       (rf_data),
      .o_pc            (ex_pc),
      .o_a             (ex_a),
      .o_b             (ex_b),
      .o_imm           (ex_imm),
      .o_shamt         (ex_shamt),
      .o_ex_ctrl       (ex_ctrl),
      .o_wb_ctrl       (wb_ctrl),
      .o_nop           (nop),
      .o_branch        (branch),
      .o_jump_rs       (jump_rs),
      .o_jump_rs_addr  (jump_rs_addr),
      .o_jump_imm      (jump_imm),
      .o_jump_imm_addr (jump_imm_addr),
      .o_rtype         (rtype)
   );

   always #20 clk = ~clk;

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_ex(input string name, input decode_pkg::ex_ctrl_t exp,
                           input decode_pkg::ex_ctrl_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic check_wb(input string name, input decode_pkg::wb_ctrl_t exp,
                           input decode_pkg::wb_ctrl_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input logic [`DATA_W-1:0] exp,
                             input logic [`DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
      end
   endtask

   // Immediate, shift and jump fields, zero extended to the widest one
   task automatic check_field(input string name, input logic [`JUMP_IMM_W-1:0] exp,
                              input logic [`JUMP_IMM_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
      end
   endtask

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   function automatic logic [`DATA_W-1:0] make_rtype(input decode_pkg::funct_e fn,
      input logic [`REG_ADDR_W-1:0] rs, input logic [`REG_ADDR_W-1:0] rt,
      input logic [`REG_ADDR_W-1:0] rd, input logic [`SHAMT_W-1:0] shamt);
      return {decode_pkg::OP_R_TYPE, rs, rt, rd, shamt, fn};
   endfunction

   function automatic logic [`DATA_W-1:0] make_itype(input decode_pkg::opcode_e op,
      input logic [`REG_ADDR_W-1:0] rs, input logic [`REG_ADDR_W-1:0] rt,
      input logic [`IMM_W-1:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [`DATA_W-1:0] make_jtype(input decode_pkg::opcode_e op,
      input logic [`JUMP_IMM_W-1:0] target);
      return {op, target};
   endfunction

   function automatic decode_pkg::ex_ctrl_t make_ex(input decode_pkg::alu_op_e op,
      input logic use_imm, input logic imm_unsigned, input logic use_shamt);
      decode_pkg::ex_ctrl_t e;
      e.alu_op       = op;
      e.use_imm      = use_imm;
      e.imm_unsigned = imm_unsigned;
      e.use_shamt    = use_shamt;
      return e;
   endfunction

   function automatic decode_pkg::wb_ctrl_t make_wb(input logic [`REG_ADDR_W-1:0] dest,
      input logic reg_we, input logic link);
      decode_pkg::wb_ctrl_t w;
      w.dest   = dest;
      w.reg_we = reg_we;
      w.link   = link;
      return w;
   endfunction

   task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr,
                            input logic [`DATA_W-1:0] data);
      @(posedge clk);
      rf_we   <= 1'b1;
      rf_addr <= addr;
      rf_data <= data;
      @(posedge clk);
      rf_we   <= 1'b0;
   endtask

   // Combinational outputs are stable at the falling edge
   task automatic issue(input logic [`DATA_W-1:0] instr);
      logic [`DATA_W-1:0] pc_val;
      @(posedge clk);
      pc_val = `DATA_W'($random(seed));
      instruction <= instr;
      pc          <= pc_val;
      last_pc      = pc_val;
      @(negedge clk);
   endtask

   // One edge of latency through the stage register
   task automatic settle();
      @(posedge clk);
      @(negedge clk);
   endtask

   task automatic report_test(input string name, input int start);
      tests++;
      if (errors == start) begin
         $display("test %s passed", name);
      end else begin
         $display("test %s failed with %0d errors", name, errors - start);
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_reset();
      int start;
      start = errors;
      check_ex("o_ex_ctrl", '0, ex_ctrl);
      check_wb("o_wb_ctrl", '0, wb_ctrl);
      check_data("o_a", 32'h0, ex_a);
      check_data("o_b", 32'h0, ex_b);
      check_bit("o_nop", 1'b0, nop);
      issue(make_rtype(decode_pkg::FN_ADDU, 5'd5, 5'd6, 5'd7, 5'd0));
      settle();
      check_data("o_a", 32'h0, ex_a);
      check_data("o_b", 32'h0, ex_b);
      report_test("reset", start);
   endtask

   task automatic test_alu_rtype();
      decode_pkg::funct_e  fns [4] = '{decode_pkg::FN_ADDU, decode_pkg::FN_SUBU,
                                       decode_pkg::FN_NOR, decode_pkg::FN_SLT};
      decode_pkg::alu_op_e ops [4] = '{decode_pkg::ALU_ADD, decode_pkg::ALU_SUB,
                                       decode_pkg::ALU_NOR, decode_pkg::ALU_SLT};
      logic [`DATA_W-1:0]     va;
      logic [`DATA_W-1:0]     vb;
      logic [`REG_ADDR_W-1:0] rd;
      int                     start;
      start = errors;
      for (int i = 0; i < 4; i++) begin
         va = `DATA_W'($random(seed));
         vb = `DATA_W'($random(seed));
         write_reg(5'd8, va);
         write_reg(5'd9, vb);
         // Last case targets register 0
         rd = (i == 3) ? 5'd0 : 5'(20 + i);
         issue(make_rtype(fns[i], 5'd8, 5'd9, rd, 5'd0));
         check_bit("o_rtype", 1'b1, rtype);
         settle();
         check_data("o_a", va, ex_a);
         check_data("o_b", vb, ex_b);
         check_ex("o_ex_ctrl", make_ex(ops[i], 1'b0, 1'b0, 1'b0), ex_ctrl);
         check_wb("o_wb_ctrl", make_wb(rd, rd != 5'd0, 1'b0), wb_ctrl);
      end
      report_test("alu_rtype", start);
   endtask

   task automatic test_immediate();
      decode_pkg::opcode_e ops [6] = '{decode_pkg::OP_ADDI, decode_pkg::OP_ANDI,
         decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_LUI, decode_pkg::OP_SLTI};
      decode_pkg::alu_op_e alus [6] = '{decode_pkg::ALU_ADD, decode_pkg::ALU_AND,
         decode_pkg::ALU_OR, decode_pkg::ALU_XOR, decode_pkg::ALU_LUI, decode_pkg::ALU_SLT};
      logic                   uns [6] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
      logic [`IMM_W-1:0]      imm;
      logic [`REG_ADDR_W-1:0] rt;
      int                     start;
      start = errors;
      for (int i = 0; i < 6; i++) begin
         imm = `IMM_W'($random(seed));
         rt  = 5'(10 + i);
         issue(make_itype(ops[i], 5'd3, rt, imm));
         check_bit("o_rtype", 1'b0, rtype);
         check_bit("o_branch", 1'b0, branch);
         settle();
         check_field("o_imm", `JUMP_IMM_W'(imm), `JUMP_IMM_W'(ex_imm));
         check_ex("o_ex_ctrl", make_ex(alus[i], 1'b1, uns[i], 1'b0), ex_ctrl);
         check_wb("o_wb_ctrl", make_wb(rt, 1'b1, 1'b0), wb_ctrl);
      end
      report_test("immediate", start);
   endtask

   task automatic test_shift();
      decode_pkg::funct_e  fns [6] = '{decode_pkg::FN_SLL, decode_pkg::FN_SRL,
         decode_pkg::FN_SRA, decode_pkg::FN_SLLV, decode_pkg::FN_SRLV, decode_pkg::FN_SRAV};
      decode_pkg::alu_op_e alus [6] = '{decode_pkg::ALU_SLL, decode_pkg::ALU_SRL,
         decode_pkg::ALU_SRA, decode_pkg::ALU_SLL, decode_pkg::ALU_SRL, decode_pkg::ALU_SRA};
      logic [`SHAMT_W-1:0] shamt;
      int                  start;
      start = errors;
      for (int i = 0; i < 6; i++) begin
         shamt = `SHAMT_W'($random(seed));
         issue(make_rtype(fns[i], 5'd4, 5'd5, 5'd17, shamt));
         settle();
         check_ex("o_ex_ctrl", make_ex(alus[i], 1'b0, 1'b0, i < 3), ex_ctrl);
         if (i < 3) begin
            check_field("o_shamt", `JUMP_IMM_W'(shamt), `JUMP_IMM_W'(ex_shamt));
         end
      end
      report_test("shift", start);
   endtask

   task automatic test_branch();
      logic [`DATA_W-1:0]     va;
      logic [`REG_ADDR_W-1:0] rt;
      logic                   ne;
      logic                   taken;
      int                     start;
      start = errors;
      va = `DATA_W'($random(seed));
      write_reg(5'd12, va);
      write_reg(5'd13, va);
      write_reg(5'd14, ~va);
      for (int i = 0; i < 4; i++) begin
         ne    = (i >= 2);
         rt    = (i % 2 == 0) ? 5'd13 : 5'd14;
         // Equal operands take BEQ, unequal take BNE
         taken = (rt == 5'd13) != ne;
         issue(make_itype(ne ? decode_pkg::OP_BNE : decode_pkg::OP_BEQ, 5'd12, rt, 16'h0040));
         check_bit("o_branch", 1'b1, branch);
         settle();
         check_bit("o_nop", taken, nop);
         check_bit("o_wb_ctrl.reg_we", 1'b0, wb_ctrl.reg_we);
      end
      report_test("branch", start);
   endtask

   task automatic test_jump();
      logic [`JUMP_IMM_W-1:0] target;
      logic [`DATA_W-1:0]     va;
      int                     start;
      start = errors;
      for (int i = 0; i < 2; i++) begin
         target = `JUMP_IMM_W'($random(seed));
         issue(make_jtype(i == 0 ? decode_pkg::OP_J : decode_pkg::OP_JAL, target));
         check_bit("o_jump_imm", 1'b1, jump_imm);
         check_bit("o_jump_rs", 1'b0, jump_rs);
         check_field("o_jump_imm_addr", target, jump_imm_addr);
         settle();
         check_bit("o_nop", 1'b1, nop);
         if (i == 1) begin
            check_wb("o_wb_ctrl", make_wb(`RA_ADDR, 1'b1, 1'b1), wb_ctrl);
            check_data("o_pc", last_pc, ex_pc);
         end
      end
      va = `DATA_W'($random(seed));
      write_reg(5'd15, va);
      for (int i = 0; i < 2; i++) begin
         issue(make_rtype(i == 0 ? decode_pkg::FN_JR : decode_pkg::FN_JALR,
                          5'd15, 5'd0, 5'd16, 5'd0));
         check_bit("o_jump_rs", 1'b1, jump_rs);
         check_bit("o_jump_imm", 1'b0, jump_imm);
         check_data("o_jump_rs_addr", va, jump_rs_addr);
         settle();
         check_bit("o_nop", 1'b1, nop);
         if (i == 1) begin
            check_wb("o_wb_ctrl", make_wb(5'd16, 1'b1, 1'b1), wb_ctrl);
         end
      end
      report_test("jump", start);
   endtask

   initial begin
      seed        = 32'hccff2c80;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      last_pc     = '0;
      clk         = 1'b0;
      rst         <= 1'b1;
      instruction <= '0;
      pc          <= '0;
      rf_we       <= 1'b0;
      rf_addr     <= '0;
      rf_data     <= '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);

      test_reset();
      test_alu_rtype();
      test_immediate();
      test_shift();
      test_branch();
      test_jump();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- rtl/decode_top.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_top (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic [`DATA_W-1:0]      i_instruction,
   input  logic [`DATA_W-1:0]      i_pc,
   input  logic                    i_rf_we,
   input  logic [`REG_ADDR_W-1:0]  i_rf_addr,
   input  logic [`DATA_W-1:0]      i_rf_data,
   output logic [`DATA_W-1:0]      o_pc,
   output logic [`DATA_W-1:0]      o_a,
   output logic [`DATA_W-1:0]      o_b,
   output logic [`IMM_W-1:0]       o_imm,
   output logic [`SHAMT_W-1:0]     o_shamt,
   output decode_pkg::ex_ctrl_t    o_ex_ctrl,
   output decode_pkg::wb_ctrl_t    o_wb_ctrl,
   output logic                    o_nop,
   output logic                    o_branch,
   output logic                    o_jump_rs,
   output logic [`DATA_W-1:0]      o_jump_rs_addr,
   output logic                    o_jump_imm,
   output logic [`JUMP_IMM_W-1:0]  o_jump_imm_addr,
   output logic                    o_rtype
);

   decode_pkg::opcode_e    opcode;
   decode_pkg::funct_e     funct;
   logic [`REG_ADDR_W-1:0] rs;
   logic [`REG_ADDR_W-1:0] rt;
   logic [`REG_ADDR_W-1:0] rd;
   logic [`IMM_W-1:0]      imm;
   logic [`SHAMT_W-1:0]    shamt;
   logic [`DATA_W-1:0]     rs_data;
   logic [`DATA_W-1:0]     rt_data;

   decode_ctrl_if ctrl_if ();

   //////////////////////////////
   // Instruction fields
   //////////////////////////////

   assign opcode          = decode_pkg::opcode_e'(i_instruction[31:26]);
   assign rs              = i_instruction[25:21];
   assign rt              = i_instruction[20:16];
   assign rd              = i_instruction[15:11];
   assign shamt           = i_instruction[10:6];
   assign funct           = decode_pkg::funct_e'(i_instruction[5:0]);
   assign imm             = i_instruction[`IMM_W-1:0];
   assign o_jump_imm_addr = i_instruction[`JUMP_IMM_W-1:0];

   // Jump outputs resolve in the decode cycle
   assign o_jump_rs      = ctrl_if.jump_rs;
   assign o_jump_rs_addr = rs_data;
   assign o_jump_imm     = ctrl_if.jump_imm;

   register_file register_file_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (i_rf_we),
      .i_waddr   (i_rf_addr),
      .i_wdata   (i_rf_data),
      .i_raddr_a (rs),
      .i_raddr_b (rt),
      .o_rdata_a (rs_data),
      .o_rdata_b (rt_data)
   );

   instruction_decoder instruction_decoder_inst (
      .i_opcode (opcode),
      .i_funct  (funct),
      .ctrl     (ctrl_if.drv),
      .o_rtype  (o_rtype)
   );

   id_ex_register id_ex_register_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .ctrl      (ctrl_if.rcv),
      .i_pc      (i_pc),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data),
      .i_rt      (rt),
      .i_rd      (rd),
      .i_imm     (imm),
      .i_shamt   (shamt),
      .o_pc      (o_pc),
      .o_a       (o_a),
      .o_b       (o_b),
      .o_imm     (o_imm),
      .o_shamt   (o_shamt),
      .o_ex_ctrl (o_ex_ctrl),
      .o_wb_ctrl (o_wb_ctrl),
      .o_nop     (o_nop),
      .o_branch  (o_branch)
   );

endmodule

//--- rtl/id_ex_register.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module id_ex_register (
   input  logic                   i_clk,
   input  logic                   i_rst,
   decode_ctrl_if.rcv             ctrl,
   input  logic [`DATA_W-1:0]     i_pc,
   input  logic [`DATA_W-1:0]     i_rs_data,
   input  logic [`DATA_W-1:0]     i_rt_data,
   input  logic [`REG_ADDR_W-1:0] i_rt,
   input  logic [`REG_ADDR_W-1:0] i_rd,
   input  logic [`IMM_W-1:0]      i_imm,
   input  logic [`SHAMT_W-1:0]    i_shamt,
   output logic [`DATA_W-1:0]     o_pc,
   output logic [`DATA_W-1:0]     o_a,
   output logic [`DATA_W-1:0]     o_b,
   output logic [`IMM_W-1:0]      o_imm,
   output logic [`SHAMT_W-1:0]    o_shamt,
   output decode_pkg::ex_ctrl_t   o_ex_ctrl,
   output decode_pkg::wb_ctrl_t   o_wb_ctrl,
   output logic                   o_nop,
   output logic                   o_branch
);

   logic [`REG_ADDR_W-1:0] dest;
   logic                   taken;
   decode_pkg::ex_ctrl_t   ex_d;
   decode_pkg::wb_ctrl_t   wb_d;

   // Immediate forms write rt, JAL writes the link register
   assign dest = ctrl.to_ra   ? `RA_ADDR :
                 ctrl.use_imm ? i_rt     : i_rd;

   // BNE flips the equality test
   assign taken = ctrl.is_branch & ((i_rs_data == i_rt_data) ^ ctrl.branch_ne);

   always_comb begin
      ex_d.alu_op       = ctrl.alu_op;
      ex_d.use_imm      = ctrl.use_imm;
      ex_d.imm_unsigned = ctrl.imm_unsigned;
      ex_d.use_shamt    = ctrl.use_shamt;
      wb_d.dest         = dest;
      wb_d.reg_we       = ctrl.reg_we && (dest != '0);
      wb_d.link         = ctrl.link;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_pc      <= '0;
         o_a       <= '0;
         o_b       <= '0;
         o_imm     <= '0;
         o_shamt   <= '0;
         o_ex_ctrl <= '0;
         o_wb_ctrl <= '0;
         o_nop     <= 1'b0;
      end else begin
         o_pc      <= i_pc;
         o_a       <= i_rs_data;
         o_b       <= i_rt_data;
         o_imm     <= i_imm;
         o_shamt   <= i_shamt;
         o_ex_ctrl <= ex_d;
         o_wb_ctrl <= wb_d;
         o_nop     <= taken | ctrl.jump_imm | ctrl.jump_rs;
      end
   end

   assign o_branch = ctrl.is_branch;

   //////////////////////////////
   // Checks
   //////////////////////////////

   a_ctrl_after_reset: assert property (
      @(posedge i_clk) $fell(i_rst) |-> (o_ex_ctrl == '0 && o_wb_ctrl == '0)
   ) else $error("control words not cleared after reset");

endmodule

//--- rtl/instruction_decoder.sv
`timescale 1ns/1ns

module instruction_decoder (
   input  decode_pkg::opcode_e i_opcode,
   input  decode_pkg::funct_e  i_funct,
   decode_ctrl_if.drv          ctrl,
   output logic                o_rtype
);

   //////////////////////////////
   // Opcode table
   //////////////////////////////

   always_comb begin
      ctrl.alu_op       = decode_pkg::ALU_ADD;
      ctrl.use_imm      = 1'b0;
      ctrl.imm_unsigned = 1'b0;
      ctrl.use_shamt    = 1'b0;
      ctrl.to_ra        = 1'b0;
      ctrl.reg_we       = 1'b0;
      ctrl.link         = 1'b0;
      ctrl.is_branch    = 1'b0;
      ctrl.branch_ne    = 1'b0;
      ctrl.jump_imm     = 1'b0;
      ctrl.jump_rs      = 1'b0;
      o_rtype           = 1'b0;

      case (i_opcode)
         decode_pkg::OP_R_TYPE: begin
            o_rtype     = 1'b1;
            ctrl.reg_we = 1'b1;
            // Function table
            case (i_funct)
               decode_pkg::FN_SLL: begin
                  ctrl.alu_op    = decode_pkg::ALU_SLL;
                  ctrl.use_shamt = 1'b1;
               end
               decode_pkg::FN_SRL: begin
                  ctrl.alu_op    = decode_pkg::ALU_SRL;
                  ctrl.use_shamt = 1'b1;
               end
               decode_pkg::FN_SRA: begin
                  ctrl.alu_op    = decode_pkg::ALU_SRA;
                  ctrl.use_shamt = 1'b1;
               end
               decode_pkg::FN_SLLV: ctrl.alu_op = decode_pkg::ALU_SLL;
               decode_pkg::FN_SRLV: ctrl.alu_op = decode_pkg::ALU_SRL;
               decode_pkg::FN_SRAV: ctrl.alu_op = decode_pkg::ALU_SRA;
               decode_pkg::FN_ADDU: ctrl.alu_op = decode_pkg::ALU_ADD;
               decode_pkg::FN_SUBU: ctrl.alu_op = decode_pkg::ALU_SUB;
               decode_pkg::FN_AND:  ctrl.alu_op = decode_pkg::ALU_AND;
               decode_pkg::FN_OR:   ctrl.alu_op = decode_pkg::ALU_OR;
               decode_pkg::FN_XOR:  ctrl.alu_op = decode_pkg::ALU_XOR;
               decode_pkg::FN_NOR:  ctrl.alu_op = decode_pkg::ALU_NOR;
               decode_pkg::FN_SLT:  ctrl.alu_op = decode_pkg::ALU_SLT;
               decode_pkg::FN_JR:   ctrl.jump_rs = 1'b1;
               decode_pkg::FN_JALR: begin
                  ctrl.jump_rs = 1'b1;
                  ctrl.link    = 1'b1;
               end
               default: ctrl.alu_op = decode_pkg::ALU_ADD;
            endcase
         end
         decode_pkg::OP_ADDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
         end
         decode_pkg::OP_SLTI: begin
            ctrl.alu_op  = decode_pkg::ALU_SLT;
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
         end
         decode_pkg::OP_ANDI: begin
            ctrl.alu_op       = decode_pkg::ALU_AND;
            ctrl.use_imm      = 1'b1;
            ctrl.imm_unsigned = 1'b1;
            ctrl.reg_we       = 1'b1;
         end
         decode_pkg::OP_ORI: begin
            ctrl.alu_op       = decode_pkg::ALU_OR;
            ctrl.use_imm      = 1'b1;
            ctrl.imm_unsigned = 1'b1;
            ctrl.reg_we       = 1'b1;
         end
         decode_pkg::OP_XORI: begin
            ctrl.alu_op       = decode_pkg::ALU_XOR;
            ctrl.use_imm      = 1'b1;
            ctrl.imm_unsigned = 1'b1;
            ctrl.reg_we       = 1'b1;
         end
         decode_pkg::OP_LUI: begin
            ctrl.alu_op       = decode_pkg::ALU_LUI;
            ctrl.use_imm      = 1'b1;
            ctrl.imm_unsigned = 1'b1;
            ctrl.reg_we       = 1'b1;
         end
         decode_pkg::OP_BEQ: begin
            ctrl.use_imm   = 1'b1;
            ctrl.is_branch = 1'b1;
         end
         decode_pkg::OP_BNE: begin
            ctrl.use_imm   = 1'b1;
            ctrl.is_branch = 1'b1;
            ctrl.branch_ne = 1'b1;
         end
         decode_pkg::OP_J: ctrl.jump_imm = 1'b1;
         decode_pkg::OP_JAL: begin
            ctrl.jump_imm = 1'b1;
            ctrl.to_ra    = 1'b1;
            ctrl.reg_we   = 1'b1;
            ctrl.link     = 1'b1;
         end
         // Loads, stores and unknown opcodes decode as a bubble
         default: o_rtype = 1'b0;
      endcase
   end

   // Jump kinds come from separate tables
   always_comb begin
      a_jump_excl: assert (!(ctrl.jump_imm && ctrl.jump_rs))
         else $error("jump_imm and jump_rs raised together");
   end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module register_file (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_we,
   input  logic [`REG_ADDR_W-1:0] i_waddr,
   input  logic [`DATA_W-1:0]     i_wdata,
   input  logic [`REG_ADDR_W-1:0] i_raddr_a,
   input  logic [`REG_ADDR_W-1:0] i_raddr_b,
   output logic [`DATA_W-1:0]     o_rdata_a,
   output logic [`DATA_W-1:0]     o_rdata_b
);

   localparam int DEPTH = 1 << `REG_ADDR_W;

   logic [`DATA_W-1:0] regs [DEPTH];

   // Register 0 is written like any other, hardwiring happens in WB control
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // No bypass, new data shows after the edge
   assign o_rdata_a = regs[i_raddr_a];
   assign o_rdata_b = regs[i_raddr_b];

   //////////////////////////////
   // Checks
   //////////////////////////////

   a_waddr_known: assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_we |-> !$isunknown(i_waddr)
   ) else $error("register file write with unknown address");

endmodule

//--- rtl/decode_ctrl_if.sv
`timescale 1ns/1ns

interface decode_ctrl_if;

   decode_pkg::alu_op_e alu_op;
   logic                use_imm;
   logic                imm_unsigned;
   logic                use_shamt;
   logic                to_ra;
   logic                reg_we;
   logic                link;
   logic                is_branch;
   logic                branch_ne;
   logic                jump_imm;
   logic                jump_rs;

   modport drv (
      output alu_op, use_imm, imm_unsigned, use_shamt, to_ra, reg_we, link,
      output is_branch, branch_ne, jump_imm, jump_rs
   );

   modport rcv (
      input alu_op, use_imm, imm_unsigned, use_shamt, to_ra, reg_we, link,
      input is_branch, branch_ne, jump_imm, jump_rs
   );

endinterface

//--- rtl/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

   typedef enum logic [5:0] {
      OP_R_TYPE = 6'b000000,
      OP_J      = 6'b000010,
      OP_JAL    = 6'b000011,
      OP_BEQ    = 6'b000100,
      OP_BNE    = 6'b000101,
      OP_ADDI   = 6'b001001,
      OP_SLTI   = 6'b001010,
      OP_ANDI   = 6'b001100,
      OP_ORI    = 6'b001101,
      OP_XORI   = 6'b001110,
      OP_LUI    = 6'b001111
   } opcode_e;

   // R-type function field
   typedef enum logic [5:0] {
      FN_SLL  = 6'b000000,
      FN_SRL  = 6'b000010,
      FN_SRA  = 6'b000011,
      FN_SLLV = 6'b000100,
      FN_SRLV = 6'b000110,
      FN_SRAV = 6'b000111,
      FN_JR   = 6'b001000,
      FN_JALR = 6'b001001,
      FN_ADDU = 6'b100001,
      FN_SUBU = 6'b100011,
      FN_AND  = 6'b100100,
      FN_OR   = 6'b100101,
      FN_XOR  = 6'b100110,
      FN_NOR  = 6'b100111,
      FN_SLT  = 6'b101010
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_NOR = 4'd5,
      ALU_SRL = 4'd6,
      ALU_SLL = 4'd7,
      ALU_SRA = 4'd8,
      ALU_SLT = 4'd10,
      ALU_LUI = 4'd11
   } alu_op_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    imm_unsigned;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic [`REG_ADDR_W-1:0] dest;
      logic                   reg_we;
      logic                   link;
   } wb_ctrl_t;

endpackage

//--- include/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath widths
`define DATA_W      32
`define REG_ADDR_W  5

// Instruction field widths
`define IMM_W       16
`define SHAMT_W     5
`define JUMP_IMM_W  26

// Link register for JAL
`define RA_ADDR     5'd31

`endif
